// ==== dv/cpu_core_sva.sv ====
`timescale 1ns/1ps

module cpu_core_sva (
	input logic                               clk,
	input logic                               rst,
	input cpu_pipe_pkg::ibus_req_t            ibus_req,
	input cpu_pipe_pkg::ibus_resp_t           ibus_resp,
	input cpu_pipe_pkg::pipeline_exec_t [1:0] commit
);

// WB clears one edge after reset is seen
commit_idle_in_reset: assert property (
	@(posedge clk) rst |=> !commit[0].valid && !commit[1].valid
) else $error("commit valid while in reset");

commit_slot_order: assert property (
	@(posedge clk) disable iff (rst) commit[1].valid |-> commit[0].valid
) else $error("commit slot 1 valid without slot 0");

// a stalled request holds until accepted
ibus_hold_on_stall: assert property (
	@(posedge clk) disable iff (rst)
	ibus_req.read && ibus_resp.stall |=> ibus_req.read && $stable(ibus_req.address)
) else $error("instruction bus request changed during stall");

ibus_addr_aligned: assert property (
	@(posedge clk) disable iff (rst) ibus_req.address[2:0] == 3'b000
) else $error("instruction bus address not 8-byte aligned");

endmodule

bind cpu_core cpu_core_sva cpu_core_sva_inst (
	.clk,
	.rst,
	.ibus_req,
	.ibus_resp,
	.commit
);

// ==== dv/cpu_core_tb.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_core_tb;

import cpu_isa_pkg::*;
import cpu_pipe_pkg::*;

localparam int RAND_LEN = 200;
// upper bound for the hand-written programs
localparam int FIXED_LEN = 64;
localparam int WATCHDOG_CYCLES = (FIXED_LEN + 2 * RAND_LEN) * 8 + 200;

localparam logic [5:0] R_FUNCTS [10] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
	FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL};
localparam logic [5:0] I_OPS [6] = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

logic                 clk;
logic                 rst;
ibus_req_t            ibus_req;
ibus_resp_t           ibus_resp;
pipeline_exec_t [1:0] commit;

uint32_t        prog [$];
pipeline_exec_t exp_q [$];
virt_t          tail_pc;
logic [31:0]    lcg_state;
logic           stall_en;
int             wait_left;
int             error_count;
int             commit_count;
int             dual_count;
int             test_count;

cpu_core UUT (
	.clk,
	.rst,
	.ibus_req  ( ibus_req  ),
	.ibus_resp ( ibus_resp ),
	.commit    ( commit    )
);

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

function automatic uint32_t enc_r(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt,
	logic [4:0] sh);
	return {6'h00, rs, rt, rd, sh, fn};
endfunction

function automatic uint32_t enc_i(logic [5:0] op, reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

// registers r0..r7 only so dependencies stay dense
function automatic uint32_t rand_instr();
	logic [31:0] r;
	logic [31:0] f;
	int          kind;
	logic [3:0]  fsel;
	logic [2:0]  osel;
	r = lcg_next();
	f = lcg_next();
	kind = int'(r[31:27]) % 18;
	fsel = 4'(kind);
	osel = 3'(kind - 10);
	if (kind < 8)
		return enc_r(R_FUNCTS[fsel], {2'b0, r[20:18]}, {2'b0, r[26:24]}, {2'b0, r[23:21]}, 5'd0);
	if (kind < 10)
		return enc_r(R_FUNCTS[fsel], {2'b0, r[20:18]}, 5'd0, {2'b0, r[23:21]}, f[15:11]);
	if (kind < 16)
		return enc_i(I_OPS[osel], {2'b0, r[23:21]}, {2'b0, r[26:24]}, f[31:16]);
	// lw and mult encodings are unsupported
	if (kind == 16)
		return enc_i(6'h23, {2'b0, r[23:21]}, {2'b0, r[26:24]}, f[31:16]);
	return enc_r(6'h18, {2'b0, r[20:18]}, {2'b0, r[26:24]}, {2'b0, r[23:21]}, 5'd0);
endfunction

// sequential ISA model of the whole program
function automatic void build_expected();
	uint32_t        regs [32];
	uint32_t        a, b, sx, zx, val;
	reg_addr_t      dst;
	uint32_t        ins;
	pipeline_exec_t e;
	regs = '{default: '0};
	exp_q.delete();
	for (int i = 0; i < prog.size(); i++) begin
		ins = prog[i];
		a = regs[ins[25:21]];
		b = regs[ins[20:16]];
		sx = {{16{ins[15]}}, ins[15:0]};
		zx = {16'h0, ins[15:0]};
		dst = ins[20:16];
		val = '0;
		case (ins[31:26])
			OP_SPECIAL: begin
				dst = ins[15:11];
				case (ins[5:0])
					FN_ADDU: val = a + b;
					FN_SUBU: val = a - b;
					FN_AND:  val = a & b;
					FN_OR:   val = a | b;
					FN_XOR:  val = a ^ b;
					FN_NOR:  val = ~(a | b);
					FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
					FN_SLL:  val = b << ins[10:6];
					FN_SRL:  val = b >> ins[10:6];
					default: dst = '0;
				endcase
			end
			OP_ADDIU: val = a + sx;
			OP_SLTI:  val = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
			OP_ANDI:  val = a & zx;
			OP_ORI:   val = a | zx;
			OP_XORI:  val = a ^ zx;
			OP_LUI:   val = {ins[15:0], 16'h0};
			default:  dst = '0;
		endcase
		if (dst == '0)
			val = '0;
		else
			regs[dst] = val;
		e = '{valid: 1'b1, pc: `RESET_PC + 32'(4 * i), rd: dst, wdata: val};
		exp_q.push_back(e);
	end
	tail_pc = `RESET_PC + 32'(4 * prog.size());
endfunction

// words past the end of the program read as no-ops
function automatic uint32_t read_word(virt_t addr);
	int idx;
	idx = int'((addr - `RESET_PC) >> 2);
	if (idx < prog.size())
		return prog[idx];
	return 32'h0;
endfunction

// instruction memory answers for the address seen after this edge
always @(posedge clk) begin
	virt_t next_addr;
	next_addr = ibus_req.address;
	if (rst)
		next_addr = `RESET_PC;
	else if (ibus_req.read && !ibus_resp.stall)
		next_addr = ibus_req.address + 32'd8;
	// each new access draws its own stall length
	if (rst || (ibus_req.read && !ibus_resp.stall))
		wait_left = stall_en ? int'(lcg_next() >> 30) : 0;
	else if (ibus_req.read && wait_left > 0)
		wait_left = wait_left - 1;
	ibus_resp.stall  <= wait_left > 0;
	ibus_resp.rddata <= {read_word(next_addr + 32'd4), read_word(next_addr)};
end

always @(posedge clk) begin
	pipeline_exec_t want;
	for (int s = 0; s < 2; s++) begin
		if (commit[s].valid) begin
			if (exp_q.size() > 0) begin
				want = exp_q.pop_front();
				commit_count++;
				if (s == 1)
					dual_count++;
			end else begin
				// past the program end the memory returns no-ops
				want = '{valid: 1'b1, pc: tail_pc, rd: 5'd0, wdata: 32'd0};
				tail_pc = tail_pc + 32'd4;
			end
			assert (commit[s].pc == want.pc && commit[s].rd == want.rd &&
				commit[s].wdata == want.wdata)
			else begin
				$display("FAIL %0t: slot %0d got pc=%h rd=%0d data=%h, want pc=%h rd=%0d data=%h",
					$time, s, commit[s].pc, commit[s].rd, commit[s].wdata,
					want.pc, want.rd, want.wdata);
				error_count++;
			end
		end
	end
end

task automatic run_program(input string name);
	int errors_before;
	int commits_before;
	errors_before = error_count;
	commits_before = commit_count;
	@(posedge clk);
	rst <= 1'b1;
	repeat (2) @(posedge clk);
	build_expected();
	dual_count = 0;
	repeat (8) @(posedge clk);
	rst <= 1'b0;
	while (exp_q.size() != 0)
		@(posedge clk);
	test_count++;
	$display("test %0d (%s) finished: %0d commits, %0d errors", test_count, name,
		commit_count - commits_before, error_count - errors_before);
endtask

initial begin
	lcg_state = 32'd53141;
	rst = 1'b1;
	ibus_resp = '0;
	stall_en = 1'b0;
	wait_left = 0;
	error_count = 0;
	commit_count = 0;
	dual_count = 0;
	test_count = 0;
	tail_pc = `RESET_PC;

	prog.push_back(enc_i(OP_LUI, 5'd1, 5'd0, 16'h1234));
	prog.push_back(enc_i(OP_ORI, 5'd2, 5'd0, 16'h5678));
	prog.push_back(enc_i(OP_ADDIU, 5'd3, 5'd0, 16'hfffb));
	prog.push_back(enc_r(FN_OR, 5'd4, 5'd1, 5'd2, 5'd0));
	prog.push_back(enc_r(FN_SLT, 5'd5, 5'd3, 5'd0, 5'd0));
	prog.push_back(enc_r(FN_SRL, 5'd6, 5'd0, 5'd4, 5'd8));
	prog.push_back(32'hfc00_0000);
	run_program("program order");

	prog.delete();
	prog.push_back(enc_i(OP_ADDIU, 5'd1, 5'd0, 16'd3));
	for (int i = 0; i < 12; i++) begin
		case (i % 4)
			0: prog.push_back(enc_r(FN_ADDU, 5'd1, 5'd1, 5'd1, 5'd0));
			1: prog.push_back(enc_i(OP_XORI, 5'd1, 5'd1, 16'h00a5));
			2: prog.push_back(enc_r(FN_SLL, 5'd1, 5'd0, 5'd1, 5'd3));
			default: prog.push_back(enc_i(OP_ADDIU, 5'd1, 5'd1, 16'hfff1));
		endcase
		// gap so the next consumer sees the producer in WB
		if (i % 3 == 2)
			repeat (3) prog.push_back(32'h0);
	end
	run_program("forwarding chain");

	prog.delete();
	for (int i = 1; i < 8; i++) begin
		prog.push_back(enc_i(OP_ORI, reg_addr_t'(i), 5'd0, 16'(i * 17)));
		prog.push_back(enc_i(OP_ADDIU, reg_addr_t'(i + 8), 5'd0, 16'(-i)));
	end
	// both slots write r20 in one cycle
	prog.push_back(enc_i(OP_ADDIU, 5'd20, 5'd0, 16'd1));
	prog.push_back(enc_i(OP_ADDIU, 5'd20, 5'd0, 16'd2));
	prog.push_back(enc_r(FN_ADDU, 5'd21, 5'd20, 5'd0, 5'd0));
	repeat (5) prog.push_back(32'h0);
	prog.push_back(enc_r(FN_ADDU, 5'd22, 5'd20, 5'd20, 5'd0));
	run_program("dual issue");
	assert (dual_count > 0)
	else begin
		$display("no cycle committed two instructions in the dual issue test");
		error_count++;
	end

	prog.delete();
	repeat (RAND_LEN) prog.push_back(rand_instr());
	run_program("random program");

	stall_en <= 1'b1;
	run_program("random program with bus stalls");

	$display("%0d tests, %0d commits checked, %0d errors", test_count, commit_count,
		error_count);
	if (error_count == 0)
		$display("Verification passed");
	else
		$display("Verification failed");
	$finish;
end

initial begin
	repeat (WATCHDOG_CYCLES) @(posedge clk);
	$display("timeout: commits stopped before all programs finished (%0d cycles)",
		WATCHDOG_CYCLES);
	$display("Verification failed");
	$finish;
end

endmodule

// ==== mini_cpu.f ====
+incdir+verilog
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/instr_fetch.sv
verilog/decode_and_issue.sv
verilog/regfile.sv
verilog/instr_exec.sv
verilog/cpu_core.sv
dv/cpu_core_sva.sv
dv/cpu_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the mini_cpu testbench with Verilator, run it and search the output for the pass line
verilator --binary --timing --assert --top-module cpu_core_tb -f mini_cpu.f -o cpu_core_tb_sim \
	&& ./obj_dir/cpu_core_tb_sim | tee /dev/stderr | grep -q "Verification passed" \
	&& echo "run_sim: simulation passed" \
	|| { echo "run_sim: simulation failed"; exit 1; }

// ==== verilog/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// instructions issued per cycle
`define ISSUE_NUM 2

// architectural registers
`define REG_NUM 32

// fetch buffer entries, power of two
`define INSTR_FIFO_DEPTH 4

// first fetch address, 8-byte aligned
`define RESET_PC 32'h0000_0000

`endif

// ==== verilog/cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_core (
	input  logic                               clk,
	input  logic                               rst,
	output cpu_pipe_pkg::ibus_req_t            ibus_req,
	input  cpu_pipe_pkg::ibus_resp_t           ibus_resp,
	output cpu_pipe_pkg::pipeline_exec_t [1:0] commit
);

import cpu_isa_pkg::*;
import cpu_pipe_pkg::*;

logic [1:0] issue_num;
fetch_entry_t [`ISSUE_NUM-1:0] fetch_entry;

// register file, two read ports per slot
reg_addr_t [2*`ISSUE_NUM-1:0] reg_raddr;
uint32_t   [2*`ISSUE_NUM-1:0] reg_rdata;
logic      [`ISSUE_NUM-1:0]   reg_we;
reg_addr_t [`ISSUE_NUM-1:0]   reg_waddr;
uint32_t   [`ISSUE_NUM-1:0]   reg_wdata;

pipeline_decode_t [`ISSUE_NUM-1:0] pipeline_decode, pipeline_decode_d;
pipeline_exec_t   [`ISSUE_NUM-1:0] pipeline_exec, pipeline_wb;

instr_fetch instr_fetch_inst (
	.clk,
	.rst,
	.issue_num   ( issue_num   ),
	.ibus_req    ( ibus_req    ),
	.ibus_resp   ( ibus_resp   ),
	.fetch_entry ( fetch_entry )
);

decode_and_issue decode_issue_inst (
	.fetch_entry     ( fetch_entry     ),
	.issue_num       ( issue_num       ),
	.reg_raddr       ( reg_raddr       ),
	.reg_rdata       ( reg_rdata       ),
	.pipeline_exec   ( pipeline_exec   ),
	.pipeline_wb     ( pipeline_wb     ),
	.pipeline_decode ( pipeline_decode )
);

regfile #(
	.REG_NUM     ( `REG_NUM       ),
	.DATA_WIDTH  ( 32             ),
	.WRITE_PORTS ( `ISSUE_NUM     ),
	.READ_PORTS  ( 2 * `ISSUE_NUM )
) regfile_inst (
	.clk,
	.rst,
	.we    ( reg_we    ),
	.waddr ( reg_waddr ),
	.wdata ( reg_wdata ),
	.raddr ( reg_raddr ),
	.rdata ( reg_rdata )
);

// ID/EX
always_ff @(posedge clk) begin
	if (rst)
		pipeline_decode_d <= '0;
	else
		pipeline_decode_d <= pipeline_decode;
end

for (genvar i = 0; i < `ISSUE_NUM; i++) begin : gen_exec
	instr_exec exec_inst (
		.data   ( pipeline_decode_d[i] ),
		.result ( pipeline_exec[i]     )
	);
end

// EX/WB, never stalls
always_ff @(posedge clk) begin
	if (rst)
		pipeline_wb <= '0;
	else
		pipeline_wb <= pipeline_exec;
end

for (genvar i = 0; i < `ISSUE_NUM; i++) begin : gen_write_back
	assign reg_we[i]    = pipeline_wb[i].valid;
	assign reg_waddr[i] = pipeline_wb[i].rd;
	assign reg_wdata[i] = pipeline_wb[i].wdata;
end

assign commit = pipeline_wb;

endmodule

// ==== verilog/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

typedef logic [31:0] uint32_t;
typedef logic [31:0] virt_t;
typedef logic [4:0]  reg_addr_t;

// major opcodes, instr[31:26]
typedef enum logic [5:0] {
	OP_SPECIAL = 6'h00,
	OP_ADDIU   = 6'h09,
	OP_SLTI    = 6'h0a,
	OP_ANDI    = 6'h0c,
	OP_ORI     = 6'h0d,
	OP_XORI    = 6'h0e,
	OP_LUI     = 6'h0f
} opcode_t;

// special function codes, instr[5:0]
typedef enum logic [5:0] {
	FN_SLL  = 6'h00,
	FN_SRL  = 6'h02,
	FN_ADDU = 6'h21,
	FN_SUBU = 6'h23,
	FN_AND  = 6'h24,
	FN_OR   = 6'h25,
	FN_XOR  = 6'h26,
	FN_NOR  = 6'h27,
	FN_SLT  = 6'h2a,
	FN_SLTU = 6'h2b
} funct_t;

typedef enum logic [3:0] {
	ALU_NOP,
	ALU_ADD,
	ALU_SUB,
	ALU_AND,
	ALU_OR,
	ALU_XOR,
	ALU_NOR,
	ALU_SLT,
	ALU_SLTU,
	ALU_SLL,
	ALU_SRL
} alu_op_t;

endpackage

// ==== verilog/cpu_pipe_pkg.sv ====
package cpu_pipe_pkg;

import cpu_isa_pkg::*;

// instruction bus, one aligned pair per access
typedef struct packed {
	logic  read;
	virt_t address;
} ibus_req_t;

typedef struct packed {
	logic        stall;
	// low word at address, high word at address+4
	logic [63:0] rddata;
} ibus_resp_t;

typedef struct packed {
	logic    valid;
	virt_t   pc;
	uint32_t instr;
} fetch_entry_t;

// ID/EX payload, operands already forwarded
typedef struct packed {
	logic      valid;
	virt_t     pc;
	alu_op_t   alu_op;
	reg_addr_t rd;
	uint32_t   op1;
	uint32_t   op2;
	logic [4:0] shamt;
} pipeline_decode_t;

// EX result, also WB stage and commit
typedef struct packed {
	logic      valid;
	virt_t     pc;
	reg_addr_t rd;
	uint32_t   wdata;
} pipeline_exec_t;

endpackage

// ==== verilog/decode_and_issue.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_and_issue (
	input  cpu_pipe_pkg::fetch_entry_t [1:0]     fetch_entry,
	output logic [1:0]                           issue_num,
	output cpu_isa_pkg::reg_addr_t [3:0]         reg_raddr,
	input  cpu_isa_pkg::uint32_t [3:0]           reg_rdata,
	input  cpu_pipe_pkg::pipeline_exec_t [1:0]   pipeline_exec,
	input  cpu_pipe_pkg::pipeline_exec_t [1:0]   pipeline_wb,
	output cpu_pipe_pkg::pipeline_decode_t [1:0] pipeline_decode
);

import cpu_isa_pkg::*;
import cpu_pipe_pkg::*;

alu_op_t   [`ISSUE_NUM-1:0] dec_op;
reg_addr_t [`ISSUE_NUM-1:0] dec_rd;
reg_addr_t [`ISSUE_NUM-1:0] src1, src2;
logic      [`ISSUE_NUM-1:0] use_imm;
uint32_t   [`ISSUE_NUM-1:0] imm;
logic      [`ISSUE_NUM-1:0] issue_slot;
uint32_t   [3:0]            operand;

always_comb begin
	for (int i = 0; i < `ISSUE_NUM; i++) begin
		dec_op[i]  = ALU_NOP;
		dec_rd[i]  = fetch_entry[i].instr[20:16];
		src1[i]    = fetch_entry[i].instr[25:21];
		src2[i]    = '0;
		use_imm[i] = 1'b1;
		imm[i]     = {16'h0, fetch_entry[i].instr[15:0]};
		case (fetch_entry[i].instr[31:26])
			OP_SPECIAL: begin
				dec_rd[i]  = fetch_entry[i].instr[15:11];
				src2[i]    = fetch_entry[i].instr[20:16];
				use_imm[i] = 1'b0;
				case (fetch_entry[i].instr[5:0])
					FN_ADDU: dec_op[i] = ALU_ADD;
					FN_SUBU: dec_op[i] = ALU_SUB;
					FN_AND:  dec_op[i] = ALU_AND;
					FN_OR:   dec_op[i] = ALU_OR;
					FN_XOR:  dec_op[i] = ALU_XOR;
					FN_NOR:  dec_op[i] = ALU_NOR;
					FN_SLT:  dec_op[i] = ALU_SLT;
					FN_SLTU: dec_op[i] = ALU_SLTU;
					FN_SLL:  dec_op[i] = ALU_SLL;
					FN_SRL:  dec_op[i] = ALU_SRL;
					default: dec_op[i] = ALU_NOP;
				endcase
				// shifts read rt only
				if (dec_op[i] == ALU_SLL || dec_op[i] == ALU_SRL)
					src1[i] = '0;
			end
			OP_ADDIU: begin
				dec_op[i] = ALU_ADD;
				imm[i]    = {{16{fetch_entry[i].instr[15]}}, fetch_entry[i].instr[15:0]};
			end
			OP_SLTI: begin
				dec_op[i] = ALU_SLT;
				imm[i]    = {{16{fetch_entry[i].instr[15]}}, fetch_entry[i].instr[15:0]};
			end
			OP_ANDI: dec_op[i] = ALU_AND;
			OP_ORI:  dec_op[i] = ALU_OR;
			OP_XORI: dec_op[i] = ALU_XOR;
			OP_LUI: begin
				// 0 | imm << 16
				dec_op[i] = ALU_OR;
				src1[i]   = '0;
				imm[i]    = {fetch_entry[i].instr[15:0], 16'h0};
			end
			default: dec_op[i] = ALU_NOP;
		endcase
		// unknown encodings write r0 and read nothing
		if (dec_op[i] == ALU_NOP) begin
			dec_rd[i] = '0;
			src1[i]   = '0;
			src2[i]   = '0;
		end
	end
end

// slot 1 waits on a RAW hazard with slot 0
assign issue_slot[0] = fetch_entry[0].valid;
assign issue_slot[1] = fetch_entry[1].valid &&
	!(dec_rd[0] != '0 && (src1[1] == dec_rd[0] || src2[1] == dec_rd[0]));
assign issue_num = {1'b0, issue_slot[0]} + {1'b0, issue_slot[1]};

always_comb begin
	for (int i = 0; i < `ISSUE_NUM; i++) begin
		reg_raddr[2*i]     = src1[i];
		reg_raddr[2*i + 1] = src2[i];
	end
end

// later assignment wins, so lowest priority goes first
always_comb begin
	for (int p = 0; p < 4; p++) begin
		operand[p] = reg_rdata[p];
		for (int s = 0; s < `ISSUE_NUM; s++) begin
			if (pipeline_wb[s].valid && pipeline_wb[s].rd == reg_raddr[p])
				operand[p] = pipeline_wb[s].wdata;
		end
		for (int s = 0; s < `ISSUE_NUM; s++) begin
			if (pipeline_exec[s].valid && pipeline_exec[s].rd == reg_raddr[p])
				operand[p] = pipeline_exec[s].wdata;
		end
		if (reg_raddr[p] == '0)
			operand[p] = '0;
	end
end

always_comb begin
	for (int i = 0; i < `ISSUE_NUM; i++) begin
		pipeline_decode[i] = '0;
		if (issue_slot[i]) begin
			pipeline_decode[i].valid  = 1'b1;
			pipeline_decode[i].pc     = fetch_entry[i].pc;
			pipeline_decode[i].alu_op = dec_op[i];
			pipeline_decode[i].rd     = dec_rd[i];
			pipeline_decode[i].op1    = operand[2*i];
			pipeline_decode[i].op2    = use_imm[i] ? imm[i] : operand[2*i + 1];
			pipeline_decode[i].shamt  = fetch_entry[i].instr[10:6];
		end
	end
end

endmodule

// ==== verilog/instr_exec.sv ====
`timescale 1ns/1ps

module instr_exec (
	input  cpu_pipe_pkg::pipeline_decode_t data,
	output cpu_pipe_pkg::pipeline_exec_t   result
);

import cpu_isa_pkg::*;

uint32_t   alu_out;
reg_addr_t rd;

always_comb begin
	case (data.alu_op)
		ALU_ADD:  alu_out = data.op1 + data.op2;
		ALU_SUB:  alu_out = data.op1 - data.op2;
		ALU_AND:  alu_out = data.op1 & data.op2;
		ALU_OR:   alu_out = data.op1 | data.op2;
		ALU_XOR:  alu_out = data.op1 ^ data.op2;
		ALU_NOR:  alu_out = ~(data.op1 | data.op2);
		ALU_SLT:  alu_out = {31'b0, $signed(data.op1) < $signed(data.op2)};
		ALU_SLTU: alu_out = {31'b0, data.op1 < data.op2};
		// shifts act on rt by shamt
		ALU_SLL:  alu_out = data.op2 << data.shamt;
		ALU_SRL:  alu_out = data.op2 >> data.shamt;
		default:  alu_out = '0;
	endcase
end

assign rd = (data.alu_op == ALU_NOP) ? '0 : data.rd;

always_comb begin
	result.valid = data.valid;
	result.pc    = data.pc;
	result.rd    = rd;
	// r0 always reads back as zero
	result.wdata = (rd == '0) ? '0 : alu_out;
end

endmodule

// ==== verilog/instr_fetch.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instr_fetch (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [1:0]                    issue_num,
	output cpu_pipe_pkg::ibus_req_t       ibus_req,
	input  cpu_pipe_pkg::ibus_resp_t      ibus_resp,
	output cpu_pipe_pkg::fetch_entry_t [1:0] fetch_entry
);

import cpu_isa_pkg::*;
import cpu_pipe_pkg::*;

localparam int PTR_W = $clog2(`INSTR_FIFO_DEPTH);
localparam int CNT_W = $clog2(`INSTR_FIFO_DEPTH + 1);

fetch_entry_t     fifo [`INSTR_FIFO_DEPTH];
logic [PTR_W-1:0] head, tail;
logic [CNT_W-1:0] count, count_next;
virt_t            pc;
logic             read_q;
logic             accept;

assign accept = read_q & ~ibus_resp.stall;
assign count_next = count + (accept ? CNT_W'(2) : CNT_W'(0)) - CNT_W'(issue_num);

always_comb begin
	ibus_req.read    = read_q;
	ibus_req.address = pc;
end

always_ff @(posedge clk) begin
	if (rst) begin
		pc     <= `RESET_PC;
		read_q <= 1'b0;
		head   <= '0;
		tail   <= '0;
		count  <= '0;
	end else begin
		// a stalled request holds; otherwise request only with room for a pair
		read_q <= (read_q & ibus_resp.stall) ||
			(int'(count_next) + 2 <= `INSTR_FIFO_DEPTH);
		head  <= head + PTR_W'(issue_num);
		count <= count_next;
		if (accept) begin
			pc   <= pc + 32'd8;
			tail <= tail + PTR_W'(2);
		end
	end
end

always_ff @(posedge clk) begin
	if (accept) begin
		fifo[tail]            <= '{valid: 1'b1, pc: pc, instr: ibus_resp.rddata[31:0]};
		fifo[tail + PTR_W'(1)] <= '{valid: 1'b1, pc: pc + 32'd4,
			instr: ibus_resp.rddata[63:32]};
	end
end

// two oldest entries, valid from the count
always_comb begin
	for (int i = 0; i < 2; i++) begin
		fetch_entry[i]       = fifo[head + PTR_W'(i)];
		fetch_entry[i].valid = count > CNT_W'(i);
	end
end

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile #(
	parameter int REG_NUM     = 32,
	parameter int DATA_WIDTH  = 32,
	parameter int WRITE_PORTS = 2,
	parameter int READ_PORTS  = 4
) (
	input  logic                                           clk,
	input  logic                                           rst,
	input  logic [WRITE_PORTS-1:0]                         we,
	input  logic [WRITE_PORTS-1:0][$clog2(REG_NUM)-1:0]    waddr,
	input  logic [WRITE_PORTS-1:0][DATA_WIDTH-1:0]         wdata,
	input  logic [READ_PORTS-1:0][$clog2(REG_NUM)-1:0]     raddr,
	output logic [READ_PORTS-1:0][DATA_WIDTH-1:0]          rdata
);

logic [DATA_WIDTH-1:0] regs [REG_NUM];

// higher port index wins on the same register
always_ff @(posedge clk) begin
	if (rst) begin
		for (int r = 0; r < REG_NUM; r++)
			regs[r] <= '0;
	end else begin
		for (int w = 0; w < WRITE_PORTS; w++) begin
			if (we[w] && waddr[w] != '0)
				regs[waddr[w]] <= wdata[w];
		end
	end
end

// no write bypass here, decode forwards from WB
always_comb begin
	for (int r = 0; r < READ_PORTS; r++)
		rdata[r] = regs[raddr[r]];
end

endmodule
